// ==== common/cpu_consts.svh ====
// Width and size constants for the CPU core

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data word width
`define XLEN 64

// Instruction word width
`define ILEN 32

// Architectural register count
`define NREGS 32

// Bits in a register number
`define RN_W 5

`endif

// ==== common/cpu_pkg.sv ====
// Shared opcode, unit and pipeline record types for the CPU core

`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8,
        OP_BEQ  = 4'd9,
        OP_BNE  = 4'd10,
        OP_JAL  = 4'd11
    } opcode_e;

    typedef enum logic [1:0] {
        UNIT_NONE   = 2'd0,
        UNIT_ALU    = 2'd1,
        UNIT_MEM    = 2'd2,
        UNIT_BRANCH = 2'd3
    } unit_e;

    // Raw instruction word layout
    typedef struct packed {
        logic [3:0]        opcode;
        logic [`RN_W-1:0]  rd;
        logic [`RN_W-1:0]  rs1;
        logic [`RN_W-1:0]  rs2;
        logic signed [12:0] imm;
    } inst_t;

    // All zero decodes to a NOP with no unit
    typedef struct packed {
        opcode_e           opcode;
        unit_e             unit;
        logic [`RN_W-1:0]  rd;
        logic [`RN_W-1:0]  rs1;
        logic [`RN_W-1:0]  rs2;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  next_pc;
    } dec_op_t;

    typedef struct packed {
        logic              valid;
        logic [`RN_W-1:0]  rd;
        logic [`XLEN-1:0]  data;
    } result_t;

endpackage

// ==== hdl/fetch.sv ====
// Fetch stage holding the PC and running the instruction bus master

`include "cpu_consts.svh"

module fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              redirect,
    input  logic [`XLEN-1:0]  redirect_pc,
    input  logic              imem_ack,
    input  logic [`ILEN-1:0]  imem_data,
    output logic              imem_req,
    output logic [`XLEN-1:0]  imem_addr,
    output logic              fe_valid,
    output logic [`ILEN-1:0]  fe_word,
    output logic [`XLEN-1:0]  fe_next_pc
);
    logic [`XLEN-1:0] pc;
    logic discard;
    logic accept;
    logic start_req;

    // Word is kept only if no redirect touched this request
    assign accept = imem_req && imem_ack && !discard && !redirect;

    // New request once ack is low and the output slot frees up
    assign start_req = !imem_req && !imem_ack && !redirect && (!fe_valid || !stall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            imem_req <= 1'b0;
            discard  <= 1'b0;
            fe_valid <= 1'b0;
        end else begin
            if (fe_valid && !stall) begin
                fe_valid <= 1'b0;
            end
            if (imem_req && imem_ack) begin
                imem_req <= 1'b0;
                discard  <= 1'b0;
                if (accept) begin
                    fe_valid <= 1'b1;
                    pc       <= pc + `XLEN'd4;
                end
            end else if (imem_req && redirect) begin
                // Let the handshake finish, then drop its word
                discard <= 1'b1;
            end else if (start_req) begin
                imem_req <= 1'b1;
            end
            if (redirect) begin
                pc       <= redirect_pc;
                fe_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            imem_addr <= pc;
        end
        if (accept) begin
            fe_word    <= imem_data;
            fe_next_pc <= imem_addr + `XLEN'd4;
        end
    end

endmodule

// ==== hdl/decode.sv ====
// Decode stage splitting a fetched word into a decoded op

`include "cpu_consts.svh"

module decode import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  logic              fe_valid,
    input  logic [`ILEN-1:0]  fe_word,
    input  logic [`XLEN-1:0]  fe_next_pc,
    output dec_op_t           de_op,
    output logic              de_valid
);
    inst_t   word;
    dec_op_t op_next;

    assign word = inst_t'(fe_word);

    always_comb begin
        op_next.opcode  = OP_NOP;
        op_next.unit    = UNIT_NONE;
        op_next.rd      = word.rd;
        op_next.rs1     = word.rs1;
        op_next.rs2     = word.rs2;
        op_next.imm     = {{(`XLEN-13){word.imm[12]}}, word.imm};
        op_next.next_pc = fe_next_pc;
        // Unused register fields are zeroed so the scoreboard ignores them
        case (word.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                op_next.opcode = opcode_e'(word.opcode);
                op_next.unit   = UNIT_ALU;
            end
            OP_ADDI: begin
                op_next.opcode = OP_ADDI;
                op_next.unit   = UNIT_ALU;
                op_next.rs2    = '0;
            end
            OP_LD: begin
                op_next.opcode = OP_LD;
                op_next.unit   = UNIT_MEM;
                op_next.rs2    = '0;
            end
            OP_ST: begin
                op_next.opcode = OP_ST;
                op_next.unit   = UNIT_MEM;
                op_next.rd     = '0;
            end
            OP_BEQ, OP_BNE: begin
                op_next.opcode = opcode_e'(word.opcode);
                op_next.unit   = UNIT_BRANCH;
                op_next.rd     = '0;
            end
            OP_JAL: begin
                op_next.opcode = OP_JAL;
                op_next.unit   = UNIT_BRANCH;
                op_next.rs1    = '0;
                op_next.rs2    = '0;
            end
            default: begin
                op_next.rd  = '0;
                op_next.rs1 = '0;
                op_next.rs2 = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
            de_op    <= '0;
        end else if (flush) begin
            de_valid <= 1'b0;
            de_op    <= '0;
        end else if (!stall) begin
            de_valid <= fe_valid;
            de_op    <= fe_valid ? op_next : '0;
        end
    end

endmodule

// ==== hdl/regfile.sv ====
// Register file with two read ports and priority commit of unit results

`include "cpu_consts.svh"

module regfile import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`RN_W-1:0]  rs1,
    input  logic [`RN_W-1:0]  rs2,
    input  result_t           alu_res,
    input  result_t           mem_res,
    input  result_t           br_res,
    output logic [`XLEN-1:0]  rs1_data,
    output logic [`XLEN-1:0]  rs2_data,
    output logic              alu_taken,
    output logic              mem_taken,
    output logic              br_taken,
    output logic [`RN_W-1:0]  wb_rd
);
    logic [`XLEN-1:0] regs [`NREGS];
    result_t          sel;
    logic             wb_valid;
    logic [`RN_W-1:0] wb_rn;
    logic [`XLEN-1:0] wb_data;

    // Memory first, then ALU, then branch
    assign mem_taken = mem_res.valid;
    assign alu_taken = alu_res.valid && !mem_res.valid;
    assign br_taken  = br_res.valid && !mem_res.valid && !alu_res.valid;
    assign sel = mem_taken ? mem_res : (alu_taken ? alu_res : br_res);

    assign wb_rd = wb_valid ? wb_rn : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= sel.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rn   <= sel.rd;
        wb_data <= sel.data;
        if (wb_valid && wb_rn != '0) begin
            regs[wb_rn] <= wb_data;
        end
        // Register 0 always reads as zero
        rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
        rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
    end

endmodule

// ==== hdl/schedule.sv ====
// In-order issue with a scoreboard of pending destination registers

`include "cpu_consts.svh"

module schedule import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  dec_op_t           de_op,
    input  logic              de_valid,
    input  logic              flush,
    input  logic [`RN_W-1:0]  wb_rd,
    input  logic              alu_busy,
    input  logic              mem_busy,
    input  logic              branch_busy,
    output logic              sc_ready,
    output dec_op_t           sc_op,
    output logic              alu_en,
    output logic              mem_en,
    output logic              branch_en
);
    logic [`NREGS-1:0] pending;
    logic regs_clear;
    logic unit_idle;
    logic issue;

    assign regs_clear = !pending[de_op.rs1] && !pending[de_op.rs2] && !pending[de_op.rd];

    always_comb begin
        case (de_op.unit)
            UNIT_ALU: unit_idle = !alu_busy && !alu_en;
            UNIT_MEM: unit_idle = !mem_busy && !mem_en;
            default:  unit_idle = 1'b1;
        endcase
    end

    // Nothing issues behind a branch until its redirect is resolved
    assign issue = de_valid && !flush && regs_clear && unit_idle &&
                   !branch_en && !branch_busy;
    assign sc_ready = !de_valid || issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= '0;
            alu_en    <= 1'b0;
            mem_en    <= 1'b0;
            branch_en <= 1'b0;
        end else begin
            pending[wb_rd] <= 1'b0;
            if (issue && de_op.rd != '0) begin
                pending[de_op.rd] <= 1'b1;
            end
            alu_en    <= issue && de_op.unit == UNIT_ALU;
            mem_en    <= issue && de_op.unit == UNIT_MEM;
            branch_en <= issue && de_op.unit == UNIT_BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            sc_op <= de_op;
        end
    end

endmodule

// ==== execute/ex_alu.sv ====
// Single-cycle ALU holding its result until commit takes it

`include "cpu_consts.svh"

module ex_alu import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  dec_op_t           op,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              taken,
    output result_t           res,
    output logic              busy
);
    logic [`XLEN-1:0] alu_out;
    logic             res_valid;
    logic [`RN_W-1:0] res_rd;
    logic [`XLEN-1:0] res_data;

    always_comb begin
        case (op.opcode)
            OP_ADD:  alu_out = rs1_data + rs2_data;
            OP_SUB:  alu_out = rs1_data - rs2_data;
            OP_AND:  alu_out = rs1_data & rs2_data;
            OP_OR:   alu_out = rs1_data | rs2_data;
            OP_XOR:  alu_out = rs1_data ^ rs2_data;
            OP_ADDI: alu_out = rs1_data + op.imm;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (en) begin
            res_valid <= 1'b1;
        end else if (taken) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            res_rd   <= op.rd;
            res_data <= alu_out;
        end
    end

    assign res  = '{valid: res_valid, rd: res_rd, data: res_data};
    assign busy = res_valid;

endmodule

// ==== execute/ex_memory.sv ====
// Load/store unit driving the four-phase data memory bus

`include "cpu_consts.svh"

module ex_memory import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  dec_op_t           op,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              taken,
    input  logic              dmem_ack,
    input  logic [`XLEN-1:0]  dmem_rdata,
    output result_t           res,
    output logic              busy,
    output logic              dmem_req,
    output logic              dmem_we,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata
);
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_REQUEST,
        MEM_WAIT_RELEASE,
        MEM_HOLD
    } mem_state_e;

    mem_state_e       state;
    logic [`RN_W-1:0] load_rd;
    logic [`XLEN-1:0] load_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= MEM_IDLE;
            dmem_req <= 1'b0;
            dmem_we  <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (en) begin
                        dmem_req <= 1'b1;
                        dmem_we  <= (op.opcode == OP_ST);
                        state    <= MEM_REQUEST;
                    end
                end
                MEM_REQUEST: begin
                    if (dmem_ack) begin
                        dmem_req <= 1'b0;
                        state    <= MEM_WAIT_RELEASE;
                    end
                end
                MEM_WAIT_RELEASE: begin
                    // Slave must drop ack before the bus is reused
                    if (!dmem_ack) begin
                        dmem_we <= 1'b0;
                        state   <= dmem_we ? MEM_IDLE : MEM_HOLD;
                    end
                end
                MEM_HOLD: begin
                    if (taken) begin
                        state <= MEM_IDLE;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM_IDLE && en) begin
            dmem_addr  <= rs1_data + op.imm;
            dmem_wdata <= rs2_data;
            load_rd    <= op.rd;
        end
        if (state == MEM_REQUEST && dmem_ack) begin
            load_data <= dmem_rdata;
        end
    end

    // Only loads reach the hold state
    assign res  = '{valid: state == MEM_HOLD, rd: load_rd, data: load_data};
    assign busy = state != MEM_IDLE;

endmodule

// ==== execute/ex_branch.sv ====
// Branch unit resolving BEQ, BNE and JAL into a redirect

`include "cpu_consts.svh"

module ex_branch import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  dec_op_t           op,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              taken,
    output result_t           res,
    output logic              busy,
    output logic              redirect,
    output logic [`XLEN-1:0]  redirect_pc
);
    logic             take;
    logic             link_valid;
    logic [`RN_W-1:0] link_rd;
    logic [`XLEN-1:0] link_data;

    always_comb begin
        case (op.opcode)
            OP_BEQ:  take = rs1_data == rs2_data;
            OP_BNE:  take = rs1_data != rs2_data;
            OP_JAL:  take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect   <= 1'b0;
            link_valid <= 1'b0;
        end else begin
            redirect <= en && take;
            if (en && op.opcode == OP_JAL && op.rd != '0) begin
                link_valid <= 1'b1;
            end else if (taken) begin
                link_valid <= 1'b0;
            end
        end
    end

    // Target is relative to the branch itself, in words
    always_ff @(posedge clk) begin
        if (en) begin
            redirect_pc <= op.next_pc - `XLEN'd4 + {op.imm[`XLEN-3:0], 2'b00};
            link_rd     <= op.rd;
            link_data   <= op.next_pc;
        end
    end

    assign res  = '{valid: link_valid, rd: link_rd, data: link_data};
    assign busy = redirect || link_valid;

endmodule

// ==== hdl/pipeline.sv ====
// Top level of the in-order pipeline with instruction and data buses

`include "cpu_consts.svh"

module pipeline import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              imem_ack,
    input  logic [`ILEN-1:0]  imem_data,
    input  logic              dmem_ack,
    input  logic [`XLEN-1:0]  dmem_rdata,
    output logic              imem_req,
    output logic [`XLEN-1:0]  imem_addr,
    output logic              dmem_req,
    output logic              dmem_we,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata
);
    logic              sc_ready;
    logic              redirect;
    logic [`XLEN-1:0]  redirect_pc;

    logic              fe_valid;
    logic [`ILEN-1:0]  fe_word;
    logic [`XLEN-1:0]  fe_next_pc;

    dec_op_t           de_op;
    logic              de_valid;

    dec_op_t           sc_op;
    logic              alu_en;
    logic              mem_en;
    logic              branch_en;

    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    logic [`RN_W-1:0]  wb_rd;

    result_t           alu_res;
    result_t           mem_res;
    result_t           br_res;
    logic              alu_taken;
    logic              mem_taken;
    logic              br_taken;
    logic              alu_busy;
    logic              mem_busy;
    logic              branch_busy;

    fetch fetch_i (
        .clk(clk), .rst_n(rst_n), .stall(!sc_ready),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_ack(imem_ack), .imem_data(imem_data),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .fe_valid(fe_valid), .fe_word(fe_word), .fe_next_pc(fe_next_pc)
    );

    decode decode_i (
        .clk(clk), .rst_n(rst_n), .stall(!sc_ready), .flush(redirect),
        .fe_valid(fe_valid), .fe_word(fe_word), .fe_next_pc(fe_next_pc),
        .de_op(de_op), .de_valid(de_valid)
    );

    // Read ports follow decode so operands line up with the issue pulse
    regfile regfile_i (
        .clk(clk), .rst_n(rst_n), .rs1(de_op.rs1), .rs2(de_op.rs2),
        .alu_res(alu_res), .mem_res(mem_res), .br_res(br_res),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_taken(alu_taken), .mem_taken(mem_taken), .br_taken(br_taken),
        .wb_rd(wb_rd)
    );

    schedule schedule_i (
        .clk(clk), .rst_n(rst_n), .de_op(de_op), .de_valid(de_valid),
        .flush(redirect), .wb_rd(wb_rd),
        .alu_busy(alu_busy), .mem_busy(mem_busy), .branch_busy(branch_busy),
        .sc_ready(sc_ready), .sc_op(sc_op),
        .alu_en(alu_en), .mem_en(mem_en), .branch_en(branch_en)
    );

    ex_alu ex_alu_i (
        .clk(clk), .rst_n(rst_n), .en(alu_en), .op(sc_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .taken(alu_taken),
        .res(alu_res), .busy(alu_busy)
    );

    ex_memory ex_memory_i (
        .clk(clk), .rst_n(rst_n), .en(mem_en), .op(sc_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .taken(mem_taken),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
        .res(mem_res), .busy(mem_busy),
        .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    ex_branch ex_branch_i (
        .clk(clk), .rst_n(rst_n), .en(branch_en), .op(sc_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .taken(br_taken),
        .res(br_res), .busy(branch_busy),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

// ==== test/pipeline_sva.sv ====
// Handshake and reset assertions for the pipeline memory buses

`include "cpu_consts.svh"

module pipeline_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             imem_req,
    input logic             imem_ack,
    input logic             dmem_req,
    input logic             dmem_ack,
    input logic             dmem_we,
    input logic [`XLEN-1:0] dmem_addr
);

    // A request stays up until the slave answers
    imem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    dmem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req)
        else $error("dmem_req dropped before dmem_ack");

    // No new request until ack is back low
    imem_no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
        !imem_req && imem_ack |=> !imem_req)
        else $error("imem_req raised while imem_ack still high");

    dmem_no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
        !dmem_req && dmem_ack |=> !dmem_req)
        else $error("dmem_req raised while dmem_ack still high");

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !imem_req && !dmem_req)
        else $error("bus request active during reset");

    dmem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req |=> !dmem_req || ($stable(dmem_addr) && $stable(dmem_we)))
        else $error("dmem_addr or dmem_we changed during a request");

endmodule

bind pipeline pipeline_sva pipeline_sva_i (
    .clk(clk), .rst_n(rst_n),
    .imem_req(imem_req), .imem_ack(imem_ack),
    .dmem_req(dmem_req), .dmem_ack(dmem_ack),
    .dmem_we(dmem_we), .dmem_addr(dmem_addr)
);

// ==== test/pipeline_tb.sv ====
// Testbench for the pipeline with bus models, a test program and store checks

`include "cpu_consts.svh"

module pipeline_tb import cpu_pkg::*; ();

    localparam int PROG_LEN        = 44;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 40;

    logic             clk = 1'b0;
    logic             rst_n = 1'b0;
    logic             imem_ack = 1'b0;
    logic [`ILEN-1:0] imem_data = '0;
    logic             dmem_ack = 1'b0;
    logic [`XLEN-1:0] dmem_rdata = '0;
    logic             imem_req;
    logic [`XLEN-1:0] imem_addr;
    logic             dmem_req;
    logic             dmem_we;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;

    // Unused program slots decode as NOP
    logic [`ILEN-1:0] prog [64] = '{default: '0};
    logic [5:0]       prog_n = '0;
    logic [`XLEN-1:0] dmem [128];
    int               imem_wait = 0;
    int               dmem_wait = 0;

    logic [`XLEN-1:0] exp_st_addr [$];
    logic [`XLEN-1:0] exp_st_data [$];
    logic [`XLEN-1:0] exp_ld_addr [$];
    logic [`XLEN-1:0] st_addr_log [$];
    logic [`XLEN-1:0] st_data_log [$];
    int               stores_seen = 0;
    int               loads_seen = 0;

    pipeline pipeline_i (
        .clk(clk), .rst_n(rst_n),
        .imem_ack(imem_ack), .imem_data(imem_data),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_store(input int idx, input logic [`XLEN-1:0] addr,
                               input logic [`XLEN-1:0] data);
        if (addr !== exp_st_addr[idx] || data !== exp_st_data[idx]) begin
            abort_run($sformatf("MISMATCH at time %0t: store %0d wrote %h to %h, expected %h to %h",
                                $time, idx, data, addr, exp_st_data[idx], exp_st_addr[idx]));
        end
    endtask

    task automatic check_load_addr(input int idx, input logic [`XLEN-1:0] addr);
        if (idx >= exp_ld_addr.size()) begin
            abort_run($sformatf("Unexpected extra load from address %h", addr));
        end else if (addr !== exp_ld_addr[idx]) begin
            abort_run($sformatf("MISMATCH at time %0t: load %0d address %h, expected %h",
                                $time, idx, addr, exp_ld_addr[idx]));
        end
    endtask

    // Preload pattern distinct for every word address
    function automatic logic [`XLEN-1:0] fill_word(input int idx);
        return {32'hC0DE_0000 + 32'(idx), 32'(idx) * 32'h9E37_79B9};
    endfunction

    task automatic put_inst(input opcode_e op, input int rd, input int rs1,
                            input int rs2, input int imm);
        inst_t w;
        w.opcode = op;
        w.rd     = `RN_W'(rd);
        w.rs1    = `RN_W'(rs1);
        w.rs2    = `RN_W'(rs2);
        w.imm    = 13'(imm);
        prog[prog_n] = w;
        prog_n = prog_n + 6'd1;
    endtask

    task automatic expect_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(data);
    endtask

    task automatic build_program();
        // ALU ops in register and immediate forms
        // x10 is the store base
        put_inst(OP_ADDI, 1, 0, 0, 100);
        put_inst(OP_ADDI, 2, 0, 0, -7);
        put_inst(OP_ADDI, 10, 0, 0, 512);
        put_inst(OP_ADD, 3, 1, 2, 0);
        put_inst(OP_SUB, 4, 1, 2, 0);
        put_inst(OP_AND, 5, 1, 2, 0);
        put_inst(OP_OR, 6, 1, 2, 0);
        put_inst(OP_XOR, 7, 1, 2, 0);
        put_inst(OP_ST, 0, 10, 3, 0);
        put_inst(OP_ST, 0, 10, 4, 8);
        put_inst(OP_ST, 0, 10, 5, 16);
        put_inst(OP_ST, 0, 10, 6, 24);
        put_inst(OP_ST, 0, 10, 7, 32);
        put_inst(OP_ADDI, 8, 1, 0, -4096);
        put_inst(OP_ST, 0, 10, 8, 40);
        // Back-to-back dependent chain on x9
        put_inst(OP_ADDI, 9, 0, 0, 1);
        put_inst(OP_ADD, 9, 9, 9, 0);
        put_inst(OP_ADD, 9, 9, 9, 0);
        put_inst(OP_SUB, 9, 9, 1, 0);
        put_inst(OP_XOR, 9, 9, 2, 0);
        put_inst(OP_ADDI, 9, 9, 0, 11);
        put_inst(OP_ST, 0, 10, 9, 48);
        // Loads with positive and negative offsets
        put_inst(OP_ADDI, 11, 0, 0, 64);
        put_inst(OP_LD, 12, 11, 0, 8);
        put_inst(OP_LD, 13, 11, 0, -16);
        put_inst(OP_ADD, 14, 12, 13, 0);
        put_inst(OP_ST, 0, 10, 12, 56);
        put_inst(OP_ST, 0, 10, 14, 64);
        // Taken branches skip stores and not-taken ones fall through
        put_inst(OP_BEQ, 0, 1, 1, 3);
        put_inst(OP_ST, 0, 10, 1, 72);
        put_inst(OP_ST, 0, 10, 1, 72);
        put_inst(OP_BNE, 0, 1, 2, 2);
        put_inst(OP_ST, 0, 10, 2, 72);
        put_inst(OP_BEQ, 0, 1, 2, 5);
        put_inst(OP_BNE, 0, 3, 3, 5);
        put_inst(OP_ST, 0, 10, 3, 72);
        // JAL at word 36 links 148
        put_inst(OP_JAL, 15, 0, 0, 3);
        put_inst(OP_ST, 0, 10, 1, 80);
        put_inst(OP_ST, 0, 10, 1, 80);
        put_inst(OP_ST, 0, 10, 15, 80);
        put_inst(OP_ADDI, 0, 1, 0, 55);
        put_inst(OP_ADD, 0, 1, 1, 0);
        put_inst(OP_ST, 0, 10, 0, 88);
        put_inst(OP_BEQ, 0, 0, 0, 0);

        expect_store(64'h200, 64'd93);
        expect_store(64'h208, 64'd107);
        expect_store(64'h210, 64'd96);
        expect_store(64'h218, 64'hFFFF_FFFF_FFFF_FFFD);
        expect_store(64'h220, 64'hFFFF_FFFF_FFFF_FF9D);
        expect_store(64'h228, 64'hFFFF_FFFF_FFFF_F064);
        expect_store(64'h230, 64'd100);
        expect_store(64'h238, fill_word(9));
        expect_store(64'h240, fill_word(9) + fill_word(6));
        expect_store(64'h248, 64'd93);
        expect_store(64'h250, 64'd148);
        expect_store(64'h258, 64'd0);
        exp_ld_addr.push_back(64'h48);
        exp_ld_addr.push_back(64'h30);
    endtask

    // Four-phase instruction memory slave with random delays
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_ack  <= 1'b0;
            imem_wait <= 0;
        end else if (imem_req != imem_ack) begin
            if (imem_wait > 0) begin
                imem_wait <= imem_wait - 1;
            end else begin
                if (imem_req) begin
                    if (imem_addr >= 64'd256) begin
                        abort_run($sformatf("Fetch from %h is outside the program", imem_addr));
                    end
                    imem_data <= prog[imem_addr[7:2]];
                end
                imem_ack  <= imem_req;
                imem_wait <= int'($urandom % 4);
            end
        end
    end

    // Data memory slave that logs stores and answers loads
    always @(negedge clk) begin
        if (!rst_n) begin
            dmem_ack  <= 1'b0;
            dmem_wait <= 0;
            for (int i = 0; i < 128; i++) begin
                dmem[i[6:0]] = fill_word(i);
            end
        end else if (dmem_req != dmem_ack) begin
            if (dmem_wait > 0) begin
                dmem_wait <= dmem_wait - 1;
            end else begin
                if (dmem_req && dmem_we) begin
                    if (stores_seen >= exp_st_addr.size()) begin
                        abort_run($sformatf("Unexpected extra store to address %h", dmem_addr));
                    end
                    st_addr_log.push_back(dmem_addr);
                    st_data_log.push_back(dmem_wdata);
                    dmem[dmem_addr[9:3]] = dmem_wdata;
                    stores_seen++;
                end else if (dmem_req) begin
                    check_load_addr(loads_seen, dmem_addr);
                    dmem_rdata <= dmem[dmem_addr[9:3]];
                    loads_seen++;
                end
                dmem_ack  <= dmem_req;
                dmem_wait <= int'($urandom % 4);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout, the program did not finish its stores in time");
    end

    initial begin
        void'($urandom(84));
        build_program();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < exp_st_addr.size(); i++) begin
            wait (stores_seen > i);
            check_store(i, st_addr_log[i], st_data_log[i]);
        end
        if (loads_seen == exp_ld_addr.size()) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("Not every expected load reached the data bus");
        end
    end

endmodule

// ==== src.f ====
+incdir+common
common/cpu_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/regfile.sv
hdl/schedule.sv
execute/ex_alu.sv
execute/ex_memory.sv
execute/ex_branch.sv
hdl/pipeline.sv
test/pipeline_sva.sv
test/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f src.f --top-module pipeline_tb \
    -Mdir obj_dir -o Vpipeline_tb

status=0
./obj_dir/Vpipeline_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
